// File: build.f
hdl/nes_loader_pkg.sv
hdl/ines_header_parser.sv
hdl/rom_load_sequencer.sv
hdl/wb_write_master.sv
hdl/nes_rom_loader.sv
dv/wb_memory_model.sv
dv/tb_nes_rom_loader.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_nes_rom_loader
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_nes_rom_loader.sv
`timescale 1ns/1ps
// Testbench for the iNES cartridge loader
// Random files with gaps in the byte stream, checked against a flag
// model and the expected write sequence logged by the memory model

module tb_nes_rom_loader
	import nes_loader_pkg::*;
();

	logic          clk;
	logic          reset_nes;
	logic          file_start;
	logic          invert_mirroring;
	logic          byte_valid;
	byte_t         byte_data;
	logic          byte_ready;
	logic          busy;
	logic          done;
	logic          error;
	mapper_flags_t mapper_flags;
	logic          wb_cyc;
	logic          wb_stb;
	logic          wb_we;
	mem_addr_t     wb_adr;
	byte_t         wb_dat_w;
	logic          wb_ack;
	logic          protocol_err;

	byte_t     file_q [$];     // Whole file as sent, trailing bytes included
	mem_addr_t exp_addr [$];
	byte_t     exp_data [$];
	byte_t     hdr_bytes [16];
	int        budget = 500;   // Cycles allowed so far
	int        cycles = 0;
	int        cyc_cycles = 0;
	int        cyc_mark;
	int        log_pos = 0;    // Log entries from earlier files
	int        kind;

	nes_rom_loader uut (.*);

	wb_memory_model mem (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	initial begin : watchdog
		forever begin
			@(posedge clk);
			cycles++;
			assert (cycles <= budget)
				else stop_run("Timeout: the loader did not finish in the expected number of cycles");
		end
	end

	always @(negedge clk) begin
		if (wb_cyc)
			cyc_cycles++;
		assert (!protocol_err) else stop_run("The memory model saw a Wishbone protocol violation");
		if (wb_cyc)
			assert (busy)
				else stop_run($sformatf("error %0t: Wishbone write while busy is low", $time));
	end

	// Smallest k up to 6 with n <= 2**k, else 7
	function automatic logic [2:0] page_code(input int n);
		int k;
		k = 0;
		while (k < 7 && n > (1 << k))
			k++;
		return 3'(k);
	endfunction

	function automatic mapper_flags_t expected_flags(input logic inv);
		mapper_flags_t f;
		logic nes2;
		logic dirty;
		int i;
		nes2  = (hdr_bytes[7][3:2] == 2'b10);
		dirty = (hdr_bytes[9][7:1] != 0);
		for (i = 10; i < 16; i++)
			dirty = dirty || (hdr_bytes[i] != 0);
		dirty = dirty && !nes2;
		f = '0;
		f[3:0]   = hdr_bytes[6][7:4];
		f[7:4]   = dirty ? 4'h0 : hdr_bytes[7][7:4];
		f[10:8]  = page_code(hdr_bytes[4]);
		f[13:11] = page_code(hdr_bytes[5]);
		f[14]    = hdr_bytes[6][0] ^ inv;
		f[15]    = (hdr_bytes[5] == 0);   // No CHR ROM means CHR RAM
		f[16]    = hdr_bytes[6][3];
		f[24:17] = nes2 ? hdr_bytes[8] : 8'h00;
		f[25]    = hdr_bytes[6][1];
		return f;
	endfunction

	// kind 0 is a good file, 1 a bad magic byte, 2 the trainer bit set
	task automatic build_file(input int file_kind);
		int i;
		int mode;
		int bad_idx;
		int n_trail;
		byte_t b;
		file_q.delete();
		exp_addr.delete();
		exp_data.delete();
		for (i = 0; i < 16; i++)
			hdr_bytes[i] = 8'($urandom);
		{hdr_bytes[0], hdr_bytes[1], hdr_bytes[2], hdr_bytes[3]} = 32'h4E45531A;
		hdr_bytes[4] = 8'($urandom_range(2, 1));
		hdr_bytes[5] = 8'($urandom_range(1, 0));
		hdr_bytes[6][2] = 1'b0;
		mode = $urandom_range(2, 0);   // NES 2.0, clean or dirty
		if (mode == 0) begin
			hdr_bytes[7][3:2] = 2'b10;
		end else begin
			if (hdr_bytes[7][3:2] == 2'b10)
				hdr_bytes[7][3:2] = 2'b00;
			if (mode == 1) begin
				hdr_bytes[9][7:1] = 7'h00;
				for (i = 10; i < 16; i++)
					hdr_bytes[i] = 8'h00;
			end else begin
				hdr_bytes[15][0] = 1'b1;
			end
		end
		if (file_kind == 1) begin
			bad_idx = $urandom_range(3, 0);
			hdr_bytes[bad_idx] ^= 8'($urandom_range(255, 1));
		end
		if (file_kind == 2)
			hdr_bytes[6][2] = 1'b1;
		for (i = 0; i < 16; i++)
			file_q.push_back(hdr_bytes[i]);
		if (file_kind == 0) begin
			for (i = 0; i < hdr_bytes[4] * 16384; i++) begin
				b = 8'($urandom);
				file_q.push_back(b);
				exp_addr.push_back(PRG_BASE + mem_addr_t'(i));
				exp_data.push_back(b);
			end
			for (i = 0; i < hdr_bytes[5] * 8192; i++) begin
				b = 8'($urandom);
				file_q.push_back(b);
				exp_addr.push_back(CHR_BASE + mem_addr_t'(i));
				exp_data.push_back(b);
			end
		end
		n_trail = (file_kind == 0) ? $urandom_range(8, 1) : 32;
		for (i = 0; i < n_trail; i++)
			file_q.push_back(8'($urandom));   // Trailing bytes, never written
		budget += file_q.size() * 12 + 200;
	endtask

	// Entered 1 ns after a rising edge and leaves at the same point
	task automatic send_file();
		int idx;
		logic taken;
		idx = 0;
		while (idx < file_q.size()) begin
			if ($urandom_range(3, 0) == 0) begin
				byte_valid = 1'b0;
				@(posedge clk);
				#1;
			end
			byte_valid = 1'b1;
			byte_data  = file_q[idx];
			do begin
				@(negedge clk);
				taken = byte_ready;
				@(posedge clk);
				#1;
			end while (!taken);
			idx++;
		end
		byte_valid = 1'b0;
	endtask

	task automatic check_load(input int file_kind);
		int i;
		if (file_kind == 0) begin
			assert (!error && !busy)
				else stop_run($sformatf("error %0t: valid file ended with error or busy", $time));
			assert (mapper_flags == expected_flags(invert_mirroring))
				else stop_run($sformatf("error %0t: mapper_flags %h, expected %h", $time,
					mapper_flags, expected_flags(invert_mirroring)));
			assert (mem.log_addr.size() == log_pos + exp_addr.size())
				else stop_run($sformatf("error %0t: %0d writes, expected %0d", $time,
					mem.log_addr.size() - log_pos, exp_addr.size()));
			for (i = 0; i < exp_addr.size(); i++) begin
				assert (mem.log_addr[log_pos + i] == exp_addr[i] &&
					mem.log_data[log_pos + i] == exp_data[i])
					else stop_run($sformatf("error %0t: write %0d is %h:%h, expected %h:%h",
						$time, i, mem.log_addr[log_pos + i], mem.log_data[log_pos + i],
						exp_addr[i], exp_data[i]));
			end
		end else begin
			assert (error)
				else stop_run($sformatf("error %0t: bad header not reported", $time));
			assert (mem.log_addr.size() == log_pos && cyc_cycles == cyc_mark)
				else stop_run($sformatf("error %0t: bus cycle seen for a bad header", $time));
		end
		log_pos = mem.log_addr.size();
	endtask

	task automatic check_idle_outputs();
		assert (!busy && !done && !error && !wb_cyc && !wb_stb && !byte_ready)
			else stop_run($sformatf("error %0t: outputs not idle around reset", $time));
	endtask

	initial begin
		reset_nes        = 1'b1;
		file_start       = 1'b0;
		invert_mirroring = 1'b0;
		byte_valid       = 1'b0;
		byte_data        = 8'h00;
		void'($urandom(32'hb04f));
		repeat (8) begin
			@(posedge clk);
			#1;
			check_idle_outputs();
		end
		reset_nes = 1'b0;
		@(negedge clk);
		check_idle_outputs();
		@(negedge clk);
		assert (byte_ready)
			else stop_run($sformatf("error %0t: byte_ready low after reset", $time));
		@(posedge clk);
		#1;

		for (int f = 0; f < 7; f++) begin
			kind = (f == 2) ? 1 : (f == 4) ? 2 : 0;
			build_file(kind);
			invert_mirroring = 1'($urandom_range(1, 0));
			cyc_mark   = cyc_cycles;
			file_start = 1'b1;
			@(posedge clk);
			#1;
			file_start = 1'b0;
			assert (!done && !error && !busy)
				else stop_run($sformatf("error %0t: file_start did not clear status", $time));
			send_file();
			while (!done) begin
				@(posedge clk);
				#1;
			end
			check_load(kind);
		end

		// A push from the last trailing byte would open a write by now
		repeat (2) @(posedge clk);
		#1;
		assert (!wb_cyc && mem.log_addr.size() == log_pos)
			else stop_run($sformatf("error %0t: write issued for trailing bytes", $time));

		$display("TEST OK");
		$finish;
	end

endmodule

// File: dv/wb_memory_model.sv
`timescale 1ns/1ps
// Wishbone classic slave memory for the loader testbench
// Logs every acked write in bus order, acks after 0 to 3 wait cycles
// and flags bus signals that move before ack

module wb_memory_model
	import nes_loader_pkg::*;
(
	input  logic      clk,
	input  logic      reset_nes,
	input  logic      wb_cyc,
	input  logic      wb_stb,
	input  logic      wb_we,
	input  mem_addr_t wb_adr,
	input  byte_t     wb_dat_w,
	output logic      wb_ack,
	output logic      protocol_err
);

	mem_addr_t log_addr [$];   // Written addresses in bus order
	byte_t     log_data [$];
	logic      slot_open;      // Write seen, ack not yet given
	logic      gap_due;        // Strobe must be low on this edge
	int        wait_left;
	mem_addr_t held_adr;
	byte_t     held_dat;

	task automatic flag_violation(input string what);
		$display("Wishbone protocol violation at %0t ns: %s", $time, what);
		protocol_err <= 1'b1;
	endtask

	always @(posedge clk) begin
		if (reset_nes) begin
			wb_ack       <= 1'b0;
			slot_open    <= 1'b0;
			gap_due      <= 1'b0;
			wait_left    <= 0;
			protocol_err <= 1'b0;
		end else begin
			gap_due <= 1'b0;
			if (gap_due)
				assert (!wb_cyc && !wb_stb && !wb_we)
					else flag_violation("cyc, stb or we stayed high after ack");
			if (wb_stb)
				assert (wb_cyc && wb_we) else flag_violation("cyc or we low with stb high");
			if (slot_open)
				assert (wb_stb && wb_adr == held_adr && wb_dat_w == held_dat)
					else flag_violation("strobe, address or data changed before ack");
			if (wb_ack) begin
				log_addr.push_back(wb_adr);
				log_data.push_back(wb_dat_w);
				wb_ack    <= 1'b0;
				slot_open <= 1'b0;
				gap_due   <= 1'b1;
			end else if (slot_open) begin
				if (wait_left == 0)
					wb_ack <= 1'b1;
				else
					wait_left <= wait_left - 1;
			end else if (wb_stb) begin
				slot_open <= 1'b1;
				held_adr  <= wb_adr;
				held_dat  <= wb_dat_w;
				wait_left <= $urandom_range(3, 0);   // Random slave latency
			end
		end
	end

endmodule

// File: hdl/nes_rom_loader.sv
`timescale 1ns/1ps
// iNES cartridge loader top level
// Header parser, load sequencer and Wishbone write master

module nes_rom_loader
	import nes_loader_pkg::*;
(
	input  logic          clk,
	input  logic          reset_nes,
	input  logic          file_start,
	input  logic          invert_mirroring,
	input  logic          byte_valid,
	input  byte_t         byte_data,
	output logic          byte_ready,
	output logic          busy,
	output logic          done,
	output logic          error,
	output mapper_flags_t mapper_flags,
	output logic          wb_cyc,
	output logic          wb_stb,
	output logic          wb_we,
	output mem_addr_t     wb_adr,
	output byte_t         wb_dat_w,
	input  logic          wb_ack
);

	logic        header_clear;
	logic        header_byte_en;
	logic        header_done;
	logic        header_ok;
	page_count_t prg_pages;
	page_count_t chr_pages;
	logic        wr_push;
	mem_addr_t   wr_addr;
	byte_t       wr_data;
	logic        wr_full;
	logic        wr_idle;

	ines_header_parser u_parser (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.header_clear     (header_clear),
		.header_byte_en   (header_byte_en),
		.byte_data        (byte_data),
		.invert_mirroring (invert_mirroring),
		.header_done      (header_done),
		.header_ok        (header_ok),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.mapper_flags     (mapper_flags)
	);

	rom_load_sequencer u_sequencer (
		.clk            (clk),
		.reset_nes      (reset_nes),
		.file_start     (file_start),
		.byte_valid     (byte_valid),
		.byte_data      (byte_data),
		.byte_ready     (byte_ready),
		.header_clear   (header_clear),
		.header_byte_en (header_byte_en),
		.header_done    (header_done),
		.header_ok      (header_ok),
		.prg_pages      (prg_pages),
		.chr_pages      (chr_pages),
		.wr_push        (wr_push),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.wr_full        (wr_full),
		.wr_idle        (wr_idle),
		.busy           (busy),
		.done           (done),
		.error          (error)
	);

	wb_write_master u_wb_master (
		.clk       (clk),
		.reset_nes (reset_nes),
		.wr_push   (wr_push),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wr_full   (wr_full),
		.wr_idle   (wr_idle),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_ack    (wb_ack)
	);

endmodule

// File: hdl/wb_write_master.sv
`timescale 1ns/1ps
// Wishbone classic write master
// Two-entry address/data queue, one single write per entry,
// with an idle cycle between consecutive writes

module wb_write_master
	import nes_loader_pkg::*;
(
	input  logic      clk,
	input  logic      reset_nes,
	input  logic      wr_push,
	input  mem_addr_t wr_addr,
	input  byte_t     wr_data,
	output logic      wr_full,
	output logic      wr_idle,
	output logic      wb_cyc,
	output logic      wb_stb,
	output logic      wb_we,
	output mem_addr_t wb_adr,
	output byte_t     wb_dat_w,
	input  logic      wb_ack
);

	mem_addr_t q_addr [2];
	byte_t     q_data [2];
	logic      wr_ptr;
	logic      rd_ptr;
	logic [1:0] count;      // Entries held, including the one on the bus
	logic      cyc_q;
	logic      pop;

	assign pop = cyc_q && wb_ack;

	assign wr_full = (count == 2'd2);
	assign wr_idle = (count == 2'd0) && !cyc_q;

	// Head entry is not overwritten while its write is open
	assign wb_cyc   = cyc_q;
	assign wb_stb   = cyc_q;
	assign wb_we    = cyc_q;
	assign wb_adr   = q_addr[rd_ptr];
	assign wb_dat_w = q_data[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_push) begin
			q_addr[wr_ptr] <= wr_addr;
			q_data[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
			cyc_q  <= 1'b0;
		end else begin
			if (wr_push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			count <= count + 2'(wr_push) - 2'(pop);

			if (pop)
				cyc_q <= 1'b0;   // Low for at least one cycle
			else if (!cyc_q && count != 2'd0)
				cyc_q <= 1'b1;
		end
	end

endmodule

// File: hdl/rom_load_sequencer.sv
`timescale 1ns/1ps
// Cartridge load sequencer
// Takes file bytes, routes the header to the parser and pushes PRG and
// CHR bytes with their addresses into the write queue

module rom_load_sequencer
	import nes_loader_pkg::*;
(
	input  logic        clk,
	input  logic        reset_nes,
	input  logic        file_start,
	input  logic        byte_valid,
	input  byte_t       byte_data,
	output logic        byte_ready,
	output logic        header_clear,
	output logic        header_byte_en,
	input  logic        header_done,
	input  logic        header_ok,
	input  page_count_t prg_pages,
	input  page_count_t chr_pages,
	output logic        wr_push,
	output mem_addr_t   wr_addr,
	output byte_t       wr_data,
	input  logic        wr_full,
	input  logic        wr_idle,
	output logic        busy,
	output logic        done,
	output logic        error
);

	load_state_t state;
	byte_count_t byte_count;   // Header bytes, then section bytes left
	mem_addr_t   addr;
	logic        live;         // Low until the first cycle out of reset
	logic        take;
	logic        in_data;

	assign in_data = (state == LOAD_PRG) || (state == LOAD_CHR);

	always_comb begin
		case (state)
			LOAD_HEADER:       byte_ready = live && (byte_count != '0);
			LOAD_PRG, LOAD_CHR: byte_ready = live && (byte_count != '0) && !wr_full;
			default:           byte_ready = live;   // Trailing bytes are dropped
		endcase
	end

	// A byte arriving with file_start belongs to the old file
	assign take = byte_valid && byte_ready && !file_start;

	assign header_clear   = file_start;
	assign header_byte_en = take && (state == LOAD_HEADER);
	assign wr_push        = take && in_data;
	assign wr_addr        = addr;
	assign wr_data        = byte_data;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			live       <= 1'b0;
			state      <= LOAD_HEADER;
			byte_count <= byte_count_t'(HEADER_BYTES);
			addr       <= PRG_BASE;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			live <= 1'b1;
			if (file_start) begin
				state      <= LOAD_HEADER;
				byte_count <= byte_count_t'(HEADER_BYTES);
				addr       <= PRG_BASE;
				busy       <= 1'b0;
				done       <= 1'b0;
				error      <= 1'b0;
			end else begin
				case (state)
					LOAD_HEADER: begin
						if (take)
							byte_count <= byte_count - 1'b1;
						if (header_done) begin
							if (header_ok) begin
								state      <= LOAD_PRG;
								busy       <= 1'b1;
								addr       <= PRG_BASE;
								byte_count <= byte_count_t'(prg_pages) << PRG_PAGE_SHIFT;
							end else begin
								state <= LOAD_ERROR;
							end
						end
					end
					LOAD_PRG, LOAD_CHR: begin
						if (byte_count == '0) begin
							if (state == LOAD_PRG) begin   // CHR section starts fresh
								state      <= LOAD_CHR;
								addr       <= CHR_BASE;
								byte_count <= byte_count_t'(chr_pages) << CHR_PAGE_SHIFT;
							end else begin
								state <= LOAD_DRAIN;
							end
						end else if (take) begin
							byte_count <= byte_count - 1'b1;
							addr       <= addr + 1'b1;
						end
					end
					LOAD_DRAIN: begin
						if (wr_idle) begin   // Last write has been acked
							state <= LOAD_DONE;
							done  <= 1'b1;
							busy  <= 1'b0;
						end
					end
					LOAD_ERROR: begin
						done  <= 1'b1;
						error <= 1'b1;
						busy  <= 1'b0;
					end
					default: ;   // LOAD_DONE holds until file_start
				endcase
			end
		end
	end

endmodule

// File: hdl/ines_header_parser.sv
`timescale 1ns/1ps
// iNES header parser
// Collects the 16 header bytes, checks magic and trainer bit,
// then registers the page counts and the 32-bit mapper flags word

module ines_header_parser
	import nes_loader_pkg::*;
(
	input  logic          clk,
	input  logic          reset_nes,
	input  logic          header_clear,
	input  logic          header_byte_en,
	input  byte_t         byte_data,
	input  logic          invert_mirroring,
	output logic          header_done,
	output logic          header_ok,
	output page_count_t   prg_pages,
	output page_count_t   chr_pages,
	output mapper_flags_t mapper_flags
);

	byte_t hdr [HEADER_BYTES];
	logic [3:0] byte_cnt;
	logic last_byte;       // Pulse after the 16th byte landed in hdr

	logic is_nes20;
	logic tail_nonzero;
	logic is_dirty;
	logic magic_ok;
	logic [7:0] mapper_num;
	mapper_flags_t flags_next;

	// Smallest k with n <= 2**k, 7 when n exceeds 64
	function automatic logic [2:0] size_code(input page_count_t n);
		logic [2:0] k;
		k = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (n <= (9'd1 << i))
				k = 3'(i);
		end
		return k;
	endfunction

	assign is_nes20 = (hdr[7][3:2] == 2'b10);
	assign magic_ok = ({hdr[0], hdr[1], hdr[2], hdr[3]} == INES_MAGIC);

	// Junk in bytes 9..15 of an old header spoils the upper mapper nibble
	always_comb begin
		tail_nonzero = |hdr[9][7:1];
		for (int i = 10; i < HEADER_BYTES; i++)
			tail_nonzero = tail_nonzero | (|hdr[i]);
	end

	assign is_dirty   = !is_nes20 && tail_nonzero;
	assign mapper_num = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};

	assign flags_next = {
		6'b0,
		hdr[6][1],                        // Battery saves
		is_nes20 ? hdr[8] : 8'h00,        // NES 2.0 extension byte
		hdr[6][3],                        // Four-screen
		(hdr[5] == 8'h00),                // CHR RAM
		hdr[6][0] ^ invert_mirroring,
		size_code(hdr[5]),
		size_code(hdr[4]),
		mapper_num
	};

	always_ff @(posedge clk) begin
		if (header_byte_en)
			hdr[byte_cnt] <= byte_data;
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			byte_cnt     <= '0;
			last_byte    <= 1'b0;
			header_done  <= 1'b0;
			header_ok    <= 1'b0;
			prg_pages    <= '0;
			chr_pages    <= '0;
			mapper_flags <= '0;
		end else begin
			last_byte   <= 1'b0;
			header_done <= last_byte && !header_clear;
			if (header_clear) begin
				byte_cnt <= '0;
			end else if (header_byte_en) begin
				byte_cnt  <= byte_cnt + 4'd1;
				last_byte <= (byte_cnt == 4'(HEADER_BYTES - 1));
			end
			if (last_byte) begin
				header_ok    <= magic_ok && !hdr[6][2];   // No trainer support
				prg_pages    <= hdr[4];
				chr_pages    <= hdr[5];
				mapper_flags <= flags_next;
			end
		end
	end

endmodule

// File: hdl/nes_loader_pkg.sv
// Shared types and constants of the iNES cartridge loader
// Widths, memory map, header magic and load FSM states

package nes_loader_pkg;

	typedef logic [7:0]  byte_t;          // File or memory data byte
	typedef logic [21:0] mem_addr_t;      // Byte address into cartridge memory
	typedef logic [21:0] byte_count_t;    // Bytes left in a section
	typedef logic [7:0]  page_count_t;    // Page count from a header byte
	typedef logic [31:0] mapper_flags_t;

	// iNES header
	localparam int HEADER_BYTES = 16;
	localparam logic [31:0] INES_MAGIC = 32'h4E45531A;   // "NES" then EOF

	// Memory map
	localparam mem_addr_t PRG_BASE = 22'h000000;
	localparam mem_addr_t CHR_BASE = 22'h200000;

	// Page sizes as shifts, 16 KiB PRG and 8 KiB CHR
	localparam int PRG_PAGE_SHIFT = 14;
	localparam int CHR_PAGE_SHIFT = 13;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_DRAIN,   // Waiting for the write queue to empty
		LOAD_DONE,
		LOAD_ERROR
	} load_state_t;

endpackage
